// ==== Makefile ====
TOP = tb_l2_tag_top

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

// ==== all.f ====
src/l2_tag_pkg.sv
src/tag_ram.sv
src/l2_tag_valid.sv
src/plru_tree.sv
src/l2_tag_ctrl.sv
src/l2_tag_top.sv
tests/tb_l2_tag_top.sv

// ==== src/l2_tag_ctrl.sv ====
`timescale 1ns/10ps

module l2_tag_ctrl
    import l2_tag_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cmd_t      cmd,
    input  set_idx_t  cmd_set,
    input  tag_t      cmd_tag,
    input  way_idx_t  cmd_way,
    output logic      ready,
    output set_idx_t  rd_set,
    output tag_t      cmp_tag,
    output set_idx_t  wr_set,
    output tag_t      wr_tag,
    output way_mask_t wr_we,
    output way_mask_t wr_inv,
    output logic      clr,
    output way_idx_t  clr_way,
    input  way_mask_t hit,
    input  way_idx_t  victim,
    output set_idx_t  lu_set,
    output logic      touch,
    output set_idx_t  touch_set,
    output way_idx_t  touch_way,
    output logic      resp_valid,
    output logic      resp_hit,
    output way_idx_t  resp_way,
    output way_idx_t  resp_victim
);

    ctrl_state_t                  state;
    logic [SET_BITS+WAY_BITS-1:0] sweep_cnt;
    logic                         is_lookup;
    logic                         is_fill;
    logic                         is_inv;
    way_mask_t                    cmd_mask;
    tag_t                         lk_tag;
    logic                         lk_valid;
    logic                         s2_valid;
    way_idx_t                     hit_way;
    logic                         hit_touch;
    logic                         fill_touch;
    logic                         hold_valid;
    set_idx_t                     hold_set;
    way_idx_t                     hold_way;

    function automatic way_idx_t encode_way(way_mask_t mask);
        way_idx_t idx;
        idx = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (mask[w]) begin
                idx = way_idx_t'(w);
            end
        end
        return idx;
    endfunction

    assign ready     = (state == ST_RUN);
    assign is_lookup = ready && (cmd == CMD_LOOKUP);
    assign is_fill   = ready && (cmd == CMD_FILL);
    assign is_inv    = ready && (cmd == CMD_INV);
    assign cmd_mask  = way_mask_t'(1) << cmd_way;

    ////////////////////////////////////////
    // Init sweep, way changes fastest
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_INIT;
            sweep_cnt <= '0;
            clr       <= 1'b0;
        end else begin
            clr <= (state == ST_INIT);
            if (state == ST_INIT) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_cnt == (SET_BITS+WAY_BITS)'(NUM_SETS * NUM_WAYS - 1)) begin
                    state <= ST_RUN;
                end
            end
        end
    end

    // Shared write address, sweep or staged command
    always_ff @(posedge clk) begin
        if (state == ST_INIT) begin
            wr_set  <= sweep_cnt[SET_BITS+WAY_BITS-1:WAY_BITS];
            clr_way <= sweep_cnt[WAY_BITS-1:0];
        end else if (is_fill || is_inv) begin
            wr_set <= cmd_set;
            wr_tag <= cmd_tag;
        end
    end

    ////////////////////////////////////////
    // Lookup pipeline
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (is_lookup) begin
            rd_set <= cmd_set;
            lk_tag <= cmd_tag;
        end
        cmp_tag     <= lk_tag;
        lu_set      <= rd_set;
        resp_hit    <= |hit;
        resp_way    <= hit_way;
        resp_victim <= victim;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_we      <= '0;
            wr_inv     <= '0;
            lk_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            wr_we      <= is_fill ? cmd_mask : '0;
            wr_inv     <= is_inv ? cmd_mask : '0;
            lk_valid   <= is_lookup;
            s2_valid   <= lk_valid;
            resp_valid <= s2_valid;
        end
    end

    ////////////////////////////////////////
    // PLRU touch merge
    ////////////////////////////////////////

    assign hit_way    = encode_way(hit);
    assign hit_touch  = s2_valid && (|hit);
    assign fill_touch = |wr_we;

    // Fill first, then a held hit, then a fresh hit
    always_comb begin
        touch     = 1'b1;
        touch_set = lu_set;
        touch_way = hit_way;
        if (fill_touch) begin
            touch_set = wr_set;
            touch_way = encode_way(wr_we);
        end else if (hold_valid) begin
            touch_set = hold_set;
            touch_way = hold_way;
        end else begin
            touch = hit_touch;
        end
    end

    // A hit that lost the arbitration waits one cycle here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (hit_touch && (fill_touch || hold_valid)) begin
            hold_valid <= 1'b1;
        end else if (!fill_touch) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_touch && (fill_touch || hold_valid)) begin
            hold_set <= lu_set;
            hold_way <= hit_way;
        end
    end

endmodule

// ==== src/l2_tag_pkg.sv ====
package l2_tag_pkg;

    ////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////

    localparam int SET_BITS = 4;
    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int TAG_BITS = 25;
    localparam int NUM_WAYS = 4;
    localparam int WAY_BITS = 2;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t;
    typedef logic [WAY_BITS-1:0] way_idx_t;

    // Command strobe encoding
    typedef enum logic [1:0] {
        CMD_NONE   = 2'd0,
        CMD_LOOKUP = 2'd1,
        CMD_FILL   = 2'd2,
        CMD_INV    = 2'd3
    } cmd_t;

    typedef enum logic {
        ST_INIT = 1'b0,
        ST_RUN  = 1'b1
    } ctrl_state_t;

endpackage

// ==== src/l2_tag_top.sv ====
`timescale 1ns/10ps

module l2_tag_top
    import l2_tag_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cmd_t     cmd,
    input  set_idx_t cmd_set,
    input  tag_t     cmd_tag,
    input  way_idx_t cmd_way,
    output logic     ready,
    output logic     resp_valid,
    output logic     resp_hit,
    output way_idx_t resp_way,
    output way_idx_t resp_victim
);

    set_idx_t  rd_set;
    tag_t      cmp_tag;
    set_idx_t  wr_set;
    tag_t      wr_tag;
    way_mask_t wr_we;
    way_mask_t wr_inv;
    logic      clr;
    way_idx_t  clr_way;
    way_mask_t hit;
    way_idx_t  victim;
    set_idx_t  lu_set;
    logic      touch;
    set_idx_t  touch_set;
    way_idx_t  touch_way;

    l2_tag_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_set     (cmd_set),
        .cmd_tag     (cmd_tag),
        .cmd_way     (cmd_way),
        .ready       (ready),
        .rd_set      (rd_set),
        .cmp_tag     (cmp_tag),
        .wr_set      (wr_set),
        .wr_tag      (wr_tag),
        .wr_we       (wr_we),
        .wr_inv      (wr_inv),
        .clr         (clr),
        .clr_way     (clr_way),
        .hit         (hit),
        .victim      (victim),
        .lu_set      (lu_set),
        .touch       (touch),
        .touch_set   (touch_set),
        .touch_way   (touch_way),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_way    (resp_way),
        .resp_victim (resp_victim)
    );

    // Valid bits are only consumed through the hit compare
    l2_tag_valid u_array (
        .clk     (clk),
        .rd_set  (rd_set),
        .cmp_tag (cmp_tag),
        .wr_set  (wr_set),
        .wr_tag  (wr_tag),
        .wr_we   (wr_we),
        .wr_inv  (wr_inv),
        .clr     (clr),
        .clr_way (clr_way),
        .hit     (hit),
        .valid   ()
    );

    plru_tree u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .lu_set    (lu_set),
        .victim    (victim),
        .touch     (touch),
        .touch_set (touch_set),
        .touch_way (touch_way)
    );

endmodule

// ==== src/l2_tag_valid.sv ====
`timescale 1ns/10ps

module l2_tag_valid
    import l2_tag_pkg::*;
(
    input  logic      clk,
    input  set_idx_t  rd_set,
    input  tag_t      cmp_tag,
    input  set_idx_t  wr_set,
    input  tag_t      wr_tag,
    input  way_mask_t wr_we,
    input  way_mask_t wr_inv,
    input  logic      clr,
    input  way_idx_t  clr_way,
    output way_mask_t hit,
    output way_mask_t valid
);

    logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
    way_mask_t           clr_mask;
    way_mask_t           kill;
    way_mask_t           fill;
    way_mask_t           valid_q;
    logic                same_set;
    tag_t                ram_din;
    tag_t                ram_tag [NUM_WAYS];

    ////////////////////////////////////////
    // Write side decode
    ////////////////////////////////////////

    // Clear beats invalidate, invalidate beats set
    always_comb begin
        clr_mask = '0;
        if (clr) begin
            clr_mask[clr_way] = 1'b1;
        end
        kill = clr ? clr_mask : wr_inv;
        fill = clr ? '0 : wr_we;
    end

    assign same_set = (wr_set == rd_set);

    // Cleared ways get an all-zero tag
    assign ram_din = clr ? '0 : wr_tag;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (kill[w]) begin
                valid_bits[w][wr_set] <= 1'b0;
            end else if (fill[w]) begin
                valid_bits[w][wr_set] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Registered valid read
    ////////////////////////////////////////

    // A write to the set being read wins over the stored bit
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (same_set && kill[w]) begin
                valid_q[w] <= 1'b0;
            end else if (same_set && fill[w]) begin
                valid_q[w] <= 1'b1;
            end else begin
                valid_q[w] <= valid_bits[w][rd_set];
            end
        end
    end

    assign valid = valid_q;

    ////////////////////////////////////////
    // Tag RAMs and compare
    ////////////////////////////////////////

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        tag_ram #(
            .WIDTH(TAG_BITS)
        ) u_tag_ram (
            .clk   (clk),
            .waddr (wr_set),
            .din   (ram_din),
            .we    (fill[w] | clr_mask[w]),
            .raddr (rd_set),
            .dout  (ram_tag[w])
        );

        assign hit[w] = valid_q[w] && (ram_tag[w] == cmp_tag);
    end

endmodule

// ==== src/plru_tree.sv ====
`timescale 1ns/10ps

module plru_tree
    import l2_tag_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  set_idx_t lu_set,
    output way_idx_t victim,
    input  logic     touch,
    input  set_idx_t touch_set,
    input  way_idx_t touch_way
);

    // Bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    logic [2:0] tree [NUM_SETS];
    logic [2:0] lu_bits;

    assign lu_bits = tree[lu_set];

    ////////////////////////////////////////
    // Victim selection
    ////////////////////////////////////////

    always_comb begin
        if (lu_bits[0]) begin
            victim = {1'b1, lu_bits[2]};
        end else begin
            victim = {1'b0, lu_bits[1]};
        end
    end

    ////////////////////////////////////////
    // Update on use
    ////////////////////////////////////////

    // Path bits are pointed away from the touched way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[touch_set][2] <= ~touch_way[0];
            end else begin
                tree[touch_set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

// ==== src/tag_ram.sv ====
`timescale 1ns/10ps

module tag_ram
    import l2_tag_pkg::*;
#(
    parameter int WIDTH = TAG_BITS
) (
    input  logic             clk,
    input  set_idx_t         waddr,
    input  logic [WIDTH-1:0] din,
    input  logic             we,
    input  set_idx_t         raddr,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] mem [1 << SET_BITS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Write-first read port
    always_ff @(posedge clk) begin
        if (we && (waddr == raddr)) begin
            dout <= din;
        end else begin
            dout <= mem[raddr];
        end
    end

endmodule

// ==== tests/tb_l2_tag_top.sv ====
`timescale 1ns/10ps

module tb_l2_tag_top
    import l2_tag_pkg::*;
();

    localparam int NUM_TESTS = 6;
    // Reset, sweep, each test with its drain cycles, then a margin
    localparam int TIMEOUT_CYCLES = 10 + 64 + (20 + 7 + 13 + 44 + 44 + 204) + 100;

    logic     clk;
    logic     rst_n;
    cmd_t     cmd;
    set_idx_t cmd_set;
    tag_t     cmd_tag;
    way_idx_t cmd_way;
    logic     ready;
    logic     resp_valid;
    logic     resp_hit;
    way_idx_t resp_way;
    way_idx_t resp_victim;

    l2_tag_top l2_tag_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_set     (cmd_set),
        .cmd_tag     (cmd_tag),
        .cmd_way     (cmd_way),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_way    (resp_way),
        .resp_victim (resp_victim)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    int          cycle_cnt = 0;
    logic [31:0] lfsr = 32'd46;
    string       test_name [NUM_TESTS];
    int          test_err [NUM_TESTS];
    int          cur_test = 0;
    int          err_total = 0;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic set_idx_t rand_set();
        return set_idx_t'(rand_bits(SET_BITS));
    endfunction

    function automatic way_idx_t rand_way();
        return way_idx_t'(rand_bits(WAY_BITS));
    endfunction

    function automatic tag_t rand_tag();
        return tag_t'(rand_bits(TAG_BITS));
    endfunction

    function automatic cmd_t rand_cmd();
        logic [1:0] b;
        b = 2'(rand_bits(2));
        return cmd_t'(b);
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    tag_t       m_tag [NUM_SETS][NUM_WAYS];
    logic       m_valid [NUM_SETS][NUM_WAYS];
    logic [2:0] m_tree [NUM_SETS];

    // Pipeline of the model: fill touch, two lookup stages, held hit
    logic     fill_v = 1'b0;
    set_idx_t fill_s;
    way_idx_t fill_w;
    logic     lk1_v = 1'b0;
    set_idx_t lk1_s;
    logic     lk1_hit;
    way_idx_t lk1_w;
    int       lk1_acc;
    int       lk1_test;
    logic     lk2_v = 1'b0;
    set_idx_t lk2_s;
    logic     lk2_hit;
    way_idx_t lk2_w;
    logic     hold_v = 1'b0;
    set_idx_t hold_s;
    way_idx_t hold_w;

    int       q_cyc [$];
    logic     q_hit [$];
    way_idx_t q_way [$];
    way_idx_t q_vic [$];
    int       q_test [$];

    function automatic way_idx_t tree_victim(input logic [2:0] bits);
        if (bits[0]) begin
            return way_idx_t'({1'b1, bits[2]});
        end
        return way_idx_t'({1'b0, bits[1]});
    endfunction

    task automatic tree_touch(input set_idx_t s, input way_idx_t w);
        m_tree[s][0] = ~w[1];
        if (w[1]) begin
            m_tree[s][2] = ~w[0];
        end else begin
            m_tree[s][1] = ~w[0];
        end
    endtask

    // Highest matching way wins when a tag sits in two ways
    task automatic model_lookup(input set_idx_t s, input tag_t t,
                                output logic hit, output way_idx_t w);
        hit = 1'b0;
        w = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (m_valid[s][i] && (m_tag[s][i] == t)) begin
                hit = 1'b1;
                w = way_idx_t'(i);
            end
        end
    endtask

    // One rising edge of the model, with the command taken at that edge
    task automatic model_edge(input cmd_t c, input set_idx_t s, input tag_t t,
                              input way_idx_t w, input int acc);
        logic     ht;
        logic     new_hit;
        way_idx_t new_way;
        ht = lk2_v && lk2_hit;
        if (fill_v) begin
            tree_touch(fill_s, fill_w);
            if (ht) begin
                hold_v = 1'b1;
                hold_s = lk2_s;
                hold_w = lk2_w;
            end
        end else if (hold_v) begin
            tree_touch(hold_s, hold_w);
            hold_v = ht;
            hold_s = lk2_s;
            hold_w = lk2_w;
        end else if (ht) begin
            tree_touch(lk2_s, lk2_w);
        end
        if (lk1_v) begin
            q_cyc.push_back(lk1_acc + 2);
            q_hit.push_back(lk1_hit);
            q_way.push_back(lk1_w);
            q_vic.push_back(tree_victim(m_tree[lk1_s]));
            q_test.push_back(lk1_test);
        end
        lk2_v = lk1_v;
        lk2_s = lk1_s;
        lk2_hit = lk1_hit;
        lk2_w = lk1_w;
        lk1_v = (c == CMD_LOOKUP);
        fill_v = (c == CMD_FILL);
        fill_s = s;
        fill_w = w;
        if (c == CMD_LOOKUP) begin
            model_lookup(s, t, new_hit, new_way);
            lk1_s = s;
            lk1_hit = new_hit;
            lk1_w = new_way;
            lk1_acc = acc;
            lk1_test = cur_test;
        end else if (c == CMD_FILL) begin
            m_tag[s][w] = t;
            m_valid[s][w] = 1'b1;
        end else if (c == CMD_INV) begin
            m_valid[s][w] = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////

    task automatic note_error(input int idx);
        test_err[idx]++;
        err_total++;
    endtask

    // Called 1 ns after an edge, returns 1 ns after the next one
    task automatic run_cycle(input cmd_t c, input set_idx_t s, input tag_t t,
                             input way_idx_t w);
        int acc;
        cmd = c;
        cmd_set = s;
        cmd_tag = t;
        cmd_way = w;
        // Past the sweep every command must find ready high
        if (c != CMD_NONE) begin
            assert (ready) else begin
                $display("[FAIL] %s ready expected 1 actual %0b",
                         test_name[cur_test], ready);
                note_error(cur_test);
            end
        end
        acc = cycle_cnt + 1;
        @(posedge clk);
        model_edge(c, s, t, w, acc);
        #1;
    endtask

    task automatic idle();
        run_cycle(CMD_NONE, '0, '0, '0);
    endtask

    task automatic finish_test(input int idx);
        repeat (4) idle();
        assert (q_cyc.size() == 0) else begin
            $display("%s: %0d responses never arrived", test_name[idx], q_cyc.size());
            note_error(idx);
        end
        q_cyc.delete();
        q_hit.delete();
        q_way.delete();
        q_vic.delete();
        q_test.delete();
        if (test_err[idx] == 0) begin
            $display("%s: passed", test_name[idx]);
        end else begin
            $display("%s: %0d errors", test_name[idx], test_err[idx]);
        end
    endtask

    int       e_cyc;
    logic     e_hit;
    way_idx_t e_way;
    way_idx_t e_vic;
    int       e_test;

    // Sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            assert (q_cyc.size() != 0) else begin
                $display("Response at cycle %0d with no lookup outstanding", cycle_cnt);
                note_error(cur_test);
            end
            if (q_cyc.size() != 0) begin
                e_cyc = q_cyc.pop_front();
                e_hit = q_hit.pop_front();
                e_way = q_way.pop_front();
                e_vic = q_vic.pop_front();
                e_test = q_test.pop_front();
                assert (cycle_cnt == e_cyc) else begin
                    $display("[FAIL] %s response cycle expected %0d actual %0d",
                             test_name[e_test], e_cyc, cycle_cnt);
                    note_error(e_test);
                end
                assert (resp_hit == e_hit) else begin
                    $display("[FAIL] %s hit expected %0b actual %0b",
                             test_name[e_test], e_hit, resp_hit);
                    note_error(e_test);
                end
                assert (!e_hit || (resp_way == e_way)) else begin
                    $display("[FAIL] %s hit way expected %0d actual %0d",
                             test_name[e_test], e_way, resp_way);
                    note_error(e_test);
                end
                assert (resp_victim == e_vic) else begin
                    $display("[FAIL] %s victim expected %0d actual %0d",
                             test_name[e_test], e_vic, resp_victim);
                    note_error(e_test);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        set_idx_t s;
        way_idx_t w;
        tag_t     t;
        int       waited;
        logic [1:0] r;
        cmd_t     c;
        test_name = '{"init_sweep", "fill_lookup", "invalidate",
                      "replacement", "forwarding", "random_mix"};
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_err[i] = 0;
        end
        for (int i = 0; i < NUM_SETS; i++) begin
            m_tree[i] = '0;
            for (int j = 0; j < NUM_WAYS; j++) begin
                m_tag[i][j] = '0;
                m_valid[i][j] = 1'b0;
            end
        end
        rst_n = 1'b0;
        cmd = CMD_NONE;
        cmd_set = '0;
        cmd_tag = '0;
        cmd_way = '0;
        repeat (10) @(posedge clk);
        #1;
        assert (!ready) else begin
            $display("ready was high while reset was asserted");
            note_error(0);
        end
        rst_n = 1'b1;

        // Sweep, then every set misses
        cur_test = 0;
        waited = 0;
        while (!ready) begin
            idle();
            waited++;
        end
        assert (waited == NUM_SETS * NUM_WAYS) else begin
            $display("[FAIL] %s sweep cycles expected %0d actual %0d",
                     test_name[0], NUM_SETS * NUM_WAYS, waited);
            note_error(0);
        end
        for (int i = 0; i < NUM_SETS; i++) begin
            run_cycle(CMD_LOOKUP, set_idx_t'(i), rand_tag(), '0);
        end
        finish_test(0);

        cur_test = 1;
        s = rand_set();
        w = rand_way();
        t = rand_tag();
        run_cycle(CMD_FILL, s, t, w);
        run_cycle(CMD_LOOKUP, s, t, '0);
        run_cycle(CMD_LOOKUP, s, t ^ tag_t'(1), '0);
        finish_test(1);

        // Four ways of one set, then drop one of them
        cur_test = 2;
        s = rand_set();
        t = rand_tag();
        for (int i = 0; i < NUM_WAYS; i++) begin
            run_cycle(CMD_FILL, s, t + tag_t'(i), way_idx_t'(i));
        end
        w = rand_way();
        run_cycle(CMD_INV, s, '0, w);
        for (int i = 0; i < NUM_WAYS; i++) begin
            run_cycle(CMD_LOOKUP, s, t + tag_t'(i), '0);
        end
        finish_test(2);

        cur_test = 3;
        s = rand_set();
        for (int i = 0; i < 40; i++) begin
            r = 2'(rand_bits(2));
            w = rand_way();
            if (r == 2'd0) begin
                run_cycle(CMD_FILL, s, rand_tag(), w);
            end else if (r == 2'd3) begin
                idle();
            end else begin
                run_cycle(CMD_LOOKUP, s, m_tag[s][w], '0);
            end
        end
        finish_test(3);

        // Fill, then a same-set lookup right behind it
        cur_test = 4;
        for (int i = 0; i < 10; i++) begin
            s = rand_set();
            w = rand_way();
            t = rand_tag();
            run_cycle(CMD_FILL, s, t, w);
            run_cycle(CMD_LOOKUP, s, t, '0);
            run_cycle(CMD_LOOKUP, rand_set(), rand_tag(), '0);
            run_cycle(CMD_LOOKUP, s, t, '0);
        end
        finish_test(4);

        cur_test = 5;
        for (int i = 0; i < 200; i++) begin
            c = rand_cmd();
            s = rand_set();
            w = rand_way();
            if (rand_bits(1) != 0) begin
                t = m_tag[s][rand_way()];
            end else begin
                t = rand_tag();
            end
            run_cycle(c, s, t, w);
        end
        finish_test(5);

        $display("Tests run %0d, errors %0d", NUM_TESTS, err_total);
        if (err_total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
